/* dcache.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_ctrl.sv
src/dcache_tags.sv
src/dcache_data.sv
src/load_extend.sv
src/dcache_top.sv
verif/dcache_chk.sv
verif/dcache_tb.sv

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl (
    input logic clk,
    input logic rst_b,
    input logic req_valid,
    output logic req_ready,
    input logic req_we,
    input logic hit,
    input logic dirty,
    input logic [`DCACHE_TAG_BITS-1:0] victim_tag,
    input logic [`DCACHE_ADDR_BITS-1:0] req_addr_q,
    output logic mem_req_valid,
    input logic mem_req_ready,
    output logic mem_we,
    output logic [`DCACHE_ADDR_BITS-1:0] mem_addr,
    input logic mem_rvalid,
    output logic resp_valid,
    input logic resp_ready,
    output logic resp_hit,
    output logic capture,
    output logic tag_update,
    output logic mark_dirty,
    output logic data_write,
    output logic data_from_mem,
    output logic resp_load
);

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_WRITEBACK = 3'd2;
    localparam logic [2:0] S_REFILL = 3'd3;
    localparam logic [2:0] S_UPDATE = 3'd4;
    localparam logic [2:0] S_RESPOND = 3'd5;

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic rd_pending_q;
    logic hit_q;
    logic [`DCACHE_INDEX_BITS-1:0] index;
    logic [`DCACHE_TAG_BITS-1:0] req_tag;

    assign index = req_addr_q[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    assign req_tag = req_addr_q[`DCACHE_ADDR_BITS-1 -: `DCACHE_TAG_BITS];

    assign req_ready = (state_q == S_IDLE);
    assign capture = req_valid && req_ready;
    assign resp_valid = (state_q == S_RESPOND);
    assign resp_hit = hit_q;

    // read request goes out once per refill
    assign mem_req_valid = (state_q == S_WRITEBACK) || ((state_q == S_REFILL) && !rd_pending_q);
    assign mem_we = (state_q == S_WRITEBACK);
    // victim address on write-back, request address on refill
    assign mem_addr = {(mem_we ? victim_tag : req_tag), index, {`DCACHE_OFFSET_BITS{1'b0}}};

    assign data_from_mem = (state_q == S_REFILL) && rd_pending_q && mem_rvalid;
    assign tag_update = data_from_mem;
    assign data_write = (state_q == S_UPDATE) && req_we;
    assign mark_dirty = data_write;
    assign resp_load = (state_q == S_UPDATE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (capture) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    state_d = S_UPDATE;
                end else if (dirty) begin
                    state_d = S_WRITEBACK;
                end else begin
                    state_d = S_REFILL;
                end
            end
            S_WRITEBACK: begin
                if (mem_req_ready) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (data_from_mem) begin
                    state_d = S_UPDATE;
                end
            end
            S_UPDATE: state_d = S_RESPOND;
            S_RESPOND: begin
                if (resp_ready) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q <= S_IDLE;
            rd_pending_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_LOOKUP) begin
                hit_q <= hit;
            end
            if ((state_q == S_REFILL) && mem_req_valid && mem_req_ready) begin
                rd_pending_q <= 1'b1;
            end else if (data_from_mem) begin
                rd_pending_q <= 1'b0;
            end
        end
    end

endmodule

/* src/dcache_data.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_data
    import dcache_pkg::*;
(
    input logic clk,
    input logic [2:0] req_funct3_q,
    input logic [`DCACHE_ADDR_BITS-1:0] req_addr_q,
    input line_word_u req_wdata_q,
    input line_word_u mem_rdata,
    input logic data_write,
    input logic data_from_mem,
    output line_word_u line_word
);

    localparam int LINES = 1 << `DCACHE_INDEX_BITS;

    line_word_u data_q [LINES];
    line_word_u merged;
    logic [`DCACHE_INDEX_BITS-1:0] index;
    logic [`DCACHE_OFFSET_BITS-1:0] offset;

    assign index = req_addr_q[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    assign offset = req_addr_q[`DCACHE_OFFSET_BITS-1:0];

    // also the write-back word
    assign line_word = data_q[index];

    // store data always sits in the low lanes
    always_comb begin
        merged = line_word;
        case (req_funct3_q)
            `F3_SB: begin
                merged.bytes[offset] = req_wdata_q.bytes[0];
            end
            `F3_SH: begin
                // bit 0 ignored
                merged.halves[offset[1]] = req_wdata_q.halves[0];
            end
            `F3_SW: begin
                merged = req_wdata_q;
            end
            default: begin
                merged = line_word;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (data_from_mem) begin
            data_q[index] <= mem_rdata;
        end else if (data_write) begin
            data_q[index] <= merged;
        end
    end

endmodule

/* src/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

    // one cache word, seen as byte lanes or halfword lanes
    typedef union packed {
        logic [`DCACHE_WORD_BITS/8-1:0][7:0] bytes;
        logic [`DCACHE_WORD_BITS/16-1:0][15:0] halves;
    } line_word_u;

endpackage

/* src/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address split
`define DCACHE_ADDR_BITS 32
`define DCACHE_INDEX_BITS 6
`define DCACHE_OFFSET_BITS 2
`define DCACHE_TAG_BITS (`DCACHE_ADDR_BITS - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)

`define DCACHE_WORD_BITS 32

// load funct3 codes
`define F3_LB 3'd0
`define F3_LH 3'd1
`define F3_LW 3'd2
`define F3_LBU 3'd4
`define F3_LHU 3'd5

// store funct3 codes
`define F3_SB 3'd0
`define F3_SH 3'd1
`define F3_SW 3'd2

`endif

/* src/dcache_tags.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tags (
    input logic clk,
    input logic rst_b,
    input logic [`DCACHE_ADDR_BITS-1:0] req_addr_q,
    input logic tag_update,
    input logic mark_dirty,
    output logic hit,
    output logic dirty,
    output logic [`DCACHE_TAG_BITS-1:0] victim_tag
);

    localparam int LINES = 1 << `DCACHE_INDEX_BITS;

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    logic [`DCACHE_TAG_BITS-1:0] tag_q [LINES];
    logic [`DCACHE_INDEX_BITS-1:0] index;
    logic [`DCACHE_TAG_BITS-1:0] req_tag;

    assign index = req_addr_q[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    assign req_tag = req_addr_q[`DCACHE_ADDR_BITS-1 -: `DCACHE_TAG_BITS];

    assign victim_tag = tag_q[index];
    assign hit = valid_q[index] && (tag_q[index] == req_tag);
    assign dirty = valid_q[index] && dirty_q[index];

    // refill installs a clean line
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (tag_update) begin
                valid_q[index] <= 1'b1;
                dirty_q[index] <= 1'b0;
            end
            if (mark_dirty) begin
                dirty_q[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_update) begin
            tag_q[index] <= req_tag;
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top
    import dcache_pkg::*;
(
    input logic clk,
    input logic rst_b,
    input logic req_valid,
    output logic req_ready,
    input logic req_we,
    input logic [2:0] req_funct3,
    input logic [`DCACHE_ADDR_BITS-1:0] req_addr,
    input logic [`DCACHE_WORD_BITS-1:0] req_wdata,
    output logic resp_valid,
    input logic resp_ready,
    output logic [`DCACHE_WORD_BITS-1:0] resp_rdata,
    output logic resp_hit,
    output logic mem_req_valid,
    input logic mem_req_ready,
    output logic mem_we,
    output logic [`DCACHE_ADDR_BITS-1:0] mem_addr,
    output logic [`DCACHE_WORD_BITS-1:0] mem_wdata,
    input logic [`DCACHE_WORD_BITS-1:0] mem_rdata,
    input logic mem_rvalid
);

    logic capture;
    logic tag_update;
    logic mark_dirty;
    logic data_write;
    logic data_from_mem;
    logic resp_load;
    logic hit;
    logic dirty;
    logic [`DCACHE_TAG_BITS-1:0] victim_tag;
    logic req_we_q;
    logic [2:0] req_funct3_q;
    logic [`DCACHE_ADDR_BITS-1:0] req_addr_q;
    line_word_u req_wdata_q;
    line_word_u line_word;
    logic [`DCACHE_WORD_BITS-1:0] load_data;

    // request held here until the response is out
    always_ff @(posedge clk) begin
        if (capture) begin
            req_we_q <= req_we;
            req_funct3_q <= req_funct3;
            req_addr_q <= req_addr;
            req_wdata_q <= req_wdata;
        end
    end

    // stores answer with zero
    always_ff @(posedge clk) begin
        if (resp_load) begin
            resp_rdata <= req_we_q ? '0 : load_data;
        end
    end

    assign mem_wdata = line_word;

    dcache_ctrl u_ctrl (
        .clk(clk),
        .rst_b(rst_b),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_we(req_we_q),
        .hit(hit),
        .dirty(dirty),
        .victim_tag(victim_tag),
        .req_addr_q(req_addr_q),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_rvalid(mem_rvalid),
        .resp_valid(resp_valid),
        .resp_ready(resp_ready),
        .resp_hit(resp_hit),
        .capture(capture),
        .tag_update(tag_update),
        .mark_dirty(mark_dirty),
        .data_write(data_write),
        .data_from_mem(data_from_mem),
        .resp_load(resp_load)
    );

    dcache_tags u_tags (
        .clk(clk),
        .rst_b(rst_b),
        .req_addr_q(req_addr_q),
        .tag_update(tag_update),
        .mark_dirty(mark_dirty),
        .hit(hit),
        .dirty(dirty),
        .victim_tag(victim_tag)
    );

    dcache_data u_data (
        .clk(clk),
        .req_funct3_q(req_funct3_q),
        .req_addr_q(req_addr_q),
        .req_wdata_q(req_wdata_q),
        .mem_rdata(mem_rdata),
        .data_write(data_write),
        .data_from_mem(data_from_mem),
        .line_word(line_word)
    );

    load_extend u_load_extend (
        .line_word(line_word),
        .req_funct3_q(req_funct3_q),
        .offset(req_addr_q[`DCACHE_OFFSET_BITS-1:0]),
        .load_data(load_data)
    );

endmodule

/* src/load_extend.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module load_extend
    import dcache_pkg::*;
(
    input line_word_u line_word,
    input logic [2:0] req_funct3_q,
    input logic [`DCACHE_OFFSET_BITS-1:0] offset,
    output logic [`DCACHE_WORD_BITS-1:0] load_data
);

    logic [7:0] sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = line_word.bytes[offset];
    // halfword lane from address bit 1
    assign sel_half = line_word.halves[offset[1]];

    always_comb begin
        case (req_funct3_q)
            `F3_LB: begin
                load_data = {{(`DCACHE_WORD_BITS-8){sel_byte[7]}}, sel_byte};
            end
            `F3_LH: begin
                load_data = {{(`DCACHE_WORD_BITS-16){sel_half[15]}}, sel_half};
            end
            `F3_LW: begin
                load_data = line_word;
            end
            `F3_LBU: begin
                load_data = {{(`DCACHE_WORD_BITS-8){1'b0}}, sel_byte};
            end
            `F3_LHU: begin
                load_data = {{(`DCACHE_WORD_BITS-16){1'b0}}, sel_half};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

/* verif/dcache_chk.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_chk (
    input logic clk,
    input logic rst_b,
    input logic req_valid,
    input logic req_ready,
    input logic resp_valid,
    input logic resp_ready,
    input logic [`DCACHE_WORD_BITS-1:0] resp_rdata,
    input logic resp_hit,
    input logic mem_req_valid,
    input logic mem_req_ready,
    input logic mem_we,
    input logic [`DCACHE_ADDR_BITS-1:0] mem_addr,
    input logic [`DCACHE_WORD_BITS-1:0] mem_wdata
);

    int fail_count = 0;
    logic in_flight_q;

    // set on accept, cleared when the response is taken
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            in_flight_q <= 1'b0;
        end else if (req_valid && req_ready) begin
            in_flight_q <= 1'b1;
        end else if (resp_valid && resp_ready) begin
            in_flight_q <= 1'b0;
        end
    end

    // stalled response keeps its contents
    resp_held: assert property (@(posedge clk) disable iff (!rst_b)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_hit))
    else begin
        $error("response changed while resp_ready was low");
        fail_count++;
    end

    mem_req_held: assert property (@(posedge clk) disable iff (!rst_b)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
    else begin
        $error("memory request changed while mem_req_ready was low");
        fail_count++;
    end

    // one request in flight
    no_accept_while_busy: assert property (@(posedge clk) disable iff (!rst_b)
        in_flight_q |-> !req_ready)
    else begin
        $error("req_ready high before the previous response was taken");
        fail_count++;
    end

endmodule

/* verif/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_WORDS = 1024;
    localparam logic [31:0] FILL_KEY = 32'h80f0_7f00;

    typedef struct packed {
        logic we;
        logic [2:0] funct3;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic hit;
    } stim_t;

    logic clk;
    logic rst_b;
    logic req_valid;
    logic req_ready;
    logic req_we;
    logic [2:0] req_funct3;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic resp_valid;
    logic resp_ready;
    logic [31:0] resp_rdata;
    logic resp_hit;
    logic mem_req_valid;
    logic mem_req_ready;
    logic mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic mem_rvalid;

    logic [31:0] mem_words [MEM_WORDS];
    logic [15:0] lfsr_q = 16'd72;
    logic [2:0] rd_wait;
    logic [31:0] rd_addr;
    logic lat_hi;
    logic lat_lo;
    stim_t stim_q[$];

    dcache_top dut (.*);

    bind dcache_top dcache_chk u_chk (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic next_random_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = galois_step(lfsr_q);
        return b;
    endfunction

    task automatic finish_failed();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic value_error(input string sig, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("CHECK FAILED time %0t: %s expected %h actual %h", $time, sig, exp, act);
        finish_failed();
    endtask

    task automatic report_failure(input string why);
        $display("ERROR at %0t: %s", $time, why);
        finish_failed();
    endtask

    function automatic void add_entry(input logic we, input logic [2:0] f3,
                                      input logic [31:0] addr, input logic [31:0] wdata,
                                      input logic [31:0] rdata, input logic hit);
        stim_q.push_back({we, f3, addr, wdata, rdata, hit});
    endfunction

    function automatic void build_table();
        // cold miss, then hits and every load kind on word 4
        add_entry(0, `F3_LW, 32'h010, 0, 32'h80f07f04, 0);
        add_entry(0, `F3_LW, 32'h010, 0, 32'h80f07f04, 1);
        add_entry(0, `F3_LB, 32'h010, 0, 32'h00000004, 1);
        add_entry(0, `F3_LB, 32'h011, 0, 32'h0000007f, 1);
        add_entry(0, `F3_LB, 32'h012, 0, 32'hfffffff0, 1);
        add_entry(0, `F3_LBU, 32'h013, 0, 32'h00000080, 1);
        add_entry(0, `F3_LH, 32'h012, 0, 32'hffff80f0, 1);
        add_entry(0, `F3_LHU, 32'h013, 0, 32'h000080f0, 1);
        add_entry(0, `F3_LH, 32'h011, 0, 32'h00007f04, 1);
        // lane merging on a hit
        add_entry(1, `F3_SB, 32'h011, 32'h000000ab, 0, 1);
        add_entry(1, `F3_SH, 32'h012, 32'h00001234, 0, 1);
        add_entry(0, `F3_LW, 32'h010, 0, 32'h1234ab04, 1);
        add_entry(0, `F3_LB, 32'h011, 0, 32'hffffffab, 1);
        add_entry(1, `F3_SW, 32'h010, 32'hdeadbeef, 0, 1);
        add_entry(0, `F3_LHU, 32'h010, 0, 32'h0000beef, 1);
        // store miss allocates
        add_entry(1, `F3_SH, 32'h022, 32'h0000cafe, 0, 0);
        add_entry(0, `F3_LW, 32'h020, 0, 32'hcafe7f08, 1);
        // conflicts on index 4 and 8 push dirty lines out
        add_entry(0, `F3_LBU, 32'h110, 0, 32'h00000044, 0);
        add_entry(0, `F3_LW, 32'h010, 0, 32'hdeadbeef, 0);
        add_entry(1, `F3_SB, 32'h323, 32'h00000011, 0, 0);
        add_entry(0, `F3_LH, 32'h322, 0, 32'h000011f0, 1);
        add_entry(0, `F3_LW, 32'h020, 0, 32'hcafe7f08, 0);
        add_entry(0, `F3_LB, 32'h320, 0, 32'hffffffc8, 0);
        add_entry(1, `F3_SW, 32'h3fc, 32'h00000001, 0, 0);
        add_entry(0, `F3_LW, 32'h3fc, 0, 32'h00000001, 1);
    endfunction

    initial begin : mem_fill
        // word address xor key
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_words[w] = w ^ FILL_KEY;
        end
    end

    // memory model with random ready, read latency and response stalls
    always @(posedge clk) begin
        if (!rst_b) begin
            mem_req_ready <= 1'b0;
            resp_ready <= 1'b0;
            mem_rvalid <= 1'b0;
            rd_wait <= '0;
        end else begin
            mem_rvalid <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_we) begin
                    mem_words[mem_addr[11:2]] <= mem_wdata;
                end else begin
                    lat_hi = next_random_bit();
                    lat_lo = next_random_bit();
                    rd_addr <= mem_addr;
                    rd_wait <= 3'd1 + {1'b0, lat_hi, lat_lo};
                end
            end
            if (rd_wait == 3'd1) begin
                mem_rvalid <= 1'b1;
                mem_rdata <= mem_words[rd_addr[11:2]];
                rd_wait <= '0;
            end else if (rd_wait > 3'd1) begin
                rd_wait <= rd_wait - 3'd1;
            end
            mem_req_ready <= next_random_bit();
            resp_ready <= next_random_bit();
        end
    end

    always @(posedge clk) begin
        assert (dut.u_chk.fail_count == 0)
        else report_failure("a handshake assertion in the bound checker failed");
    end

    initial begin : watchdog
        #1;
        #(CLK_PERIOD * (RESET_CYCLES + stim_q.size() * 40));
        report_failure("watchdog expired before the stimulus table finished");
    end

    initial begin : main
        stim_t e;
        int cycles;
        clk = 1'b0;
        rst_b = 1'b0;
        req_valid = 1'b0;
        req_we = 1'b0;
        req_funct3 = '0;
        req_addr = '0;
        req_wdata = '0;
        resp_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_rdata = '0;
        mem_rvalid = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_b <= 1'b1;
        foreach (stim_q[i]) begin
            e = stim_q[i];
            @(posedge clk);
            req_valid <= 1'b1;
            req_we <= e.we;
            req_funct3 <= e.funct3;
            req_addr <= e.addr;
            req_wdata <= e.wdata;
            do begin
                @(posedge clk);
                assert (!resp_valid) else report_failure("response with no request in flight");
            end while (!req_ready);
            req_valid <= 1'b0;
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
            end while (!resp_valid);
            assert (resp_hit === e.hit) else value_error("resp_hit", e.hit, resp_hit);
            assert (resp_rdata === e.rdata) else value_error("resp_rdata", e.rdata, resp_rdata);
            // resp_valid rose one edge before it was seen
            if (e.hit) begin
                assert (cycles - 1 == 2) else value_error("hit latency", 2, cycles - 1);
            end
            while (!resp_ready) @(posedge clk);
        end
        // write-backs recorded by the memory model
        assert (mem_words[4] === 32'hdeadbeef)
        else value_error("mem_words[4]", 32'hdeadbeef, mem_words[4]);
        assert (mem_words[8] === 32'hcafe7f08)
        else value_error("mem_words[8]", 32'hcafe7f08, mem_words[8]);
        assert (mem_words[200] === 32'h11f07fc8)
        else value_error("mem_words[200]", 32'h11f07fc8, mem_words[200]);
        repeat (2) @(posedge clk);
        if (dut.u_chk.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            finish_failed();
        end
    end

endmodule
